// File: Bender.yml
package:
  name: la_core

sources:
  - logic/la_pkg.sv
  - logic/bus_sampler.sv
  - logic/trigger_config.sv
  - logic/bus_comparator.sv
  - logic/route_combiner.sv
  - logic/recorder.sv
  - logic/la_top.sv
  - target: test
    files:
      - tb/la_assertions.sv
      - tb/la_tb.sv

// File: logic/bus_comparator.sv
module bus_comparator #(
	parameter int NUM_ROUTES = 6
) (
	input  logic                  pllclk,
	input  logic                  f_reset,

	input  la_pkg::sample_t       sample,
	input  la_pkg::sample_t       value,
	input  la_pkg::sample_t       mask,
	input  logic [NUM_ROUTES-1:0] level_routes,
	input  logic [NUM_ROUTES-1:0] edge_routes,

	output logic [NUM_ROUTES-1:0] level_out,
	output logic [NUM_ROUTES-1:0] edge_out
);

	logic match;
	logic prev_match;

	// only bits set in the mask take part.
	assign match = ((sample ^ value) & mask) == '0;

	always_ff @(posedge pllclk) begin
		if (f_reset) begin
			prev_match <= 1'b0;
			level_out  <= '0;
			edge_out   <= '0;
		end else begin
			prev_match <= match;
			level_out  <= match ? level_routes : '0;
			edge_out   <= (match && !prev_match) ? edge_routes : '0; // first matching cycle.
		end
	end

endmodule

// File: logic/bus_sampler.sv
module bus_sampler (
	input  logic           pllclk,
	input  logic           f_reset,

	input  logic [14:0]    adr,
	input  logic [7:0]     data,
	input  logic           n_rd,
	input  logic           n_wr,
	input  logic           n_cs_rom,
	input  logic           n_cs_xram,
	input  logic           n_reset,
	input  logic           phi,

	output la_pkg::sample_t sample
);

	always_ff @(posedge pllclk) begin
		if (f_reset) begin
			sample <= '0;
		end else begin
			sample.reset   <= !n_reset; // strobes are active low on the bus.
			sample.phi     <= phi;
			sample.wr      <= !n_wr;
			sample.rd      <= !n_rd;
			sample.cs_xram <= !n_cs_xram;
			sample.data    <= data;
			sample.cs_rom  <= !n_cs_rom;
			sample.adr     <= adr;
		end
	end

endmodule

// File: logic/la_pkg.sv
package la_pkg;

	// width of one bus sample.
	localparam int SAMPLE_W = 29;

	// width of a configuration data word.
	localparam int CFG_DATA_W = 32;

	// one bus sample; every field is active high.
	typedef struct packed {
		logic        reset;
		logic        phi;
		logic        wr;
		logic        rd;
		logic        cs_xram;
		logic [7:0]  data;
		logic        cs_rom;
		logic [14:0] adr;
	} sample_t;

	// configuration register selector.
	typedef enum logic [3:0] {
		CFG_ONES_SET           = 4'd0,
		CFG_CMP_VALUE          = 4'd1, // comparator registers use cfg_sel.
		CFG_CMP_MASK           = 4'd2,
		CFG_CMP_LEVEL_ROUTES   = 4'd3,
		CFG_CMP_EDGE_ROUTES    = 4'd4,
		CFG_REC_START_ROUTES   = 4'd5,
		CFG_REC_STOP_ROUTES    = 4'd6,
		CFG_REC_CAPTURE_ROUTES = 4'd7,
		CFG_REC_CONTROL        = 4'd8
	} cfg_reg_e;

	// bit positions of the recorder commands in a control word.
	// the new recording address sits in bits 31:16.
	typedef enum logic [4:0] {
		REC_CMD_START   = 5'd0,
		REC_CMD_STOP    = 5'd1,
		REC_CMD_CAPTURE = 5'd2,
		REC_CMD_SET_ADR = 5'd3
	} rec_cmd_e;

endpackage

// File: logic/la_top.sv
module la_top #(
	parameter int NUM_CMP    = 2,
	parameter int NUM_ROUTES = 6,
	parameter int REC_DEPTH  = 256,
	localparam int SEL_W     = (NUM_CMP > 1) ? $clog2(NUM_CMP) : 1,
	localparam int ADR_W     = $clog2(REC_DEPTH)
) (
	input  logic                          pllclk,
	input  logic                          f_reset,

	input  logic [14:0]                   adr,
	input  logic [7:0]                    data,
	input  logic                          n_rd,
	input  logic                          n_wr,
	input  logic                          n_cs_rom,
	input  logic                          n_cs_xram,
	input  logic                          n_reset,
	input  logic                          phi,

	input  logic                          cfg_wr,
	input  la_pkg::cfg_reg_e              cfg_reg,
	input  logic [SEL_W-1:0]              cfg_sel,
	input  logic [la_pkg::CFG_DATA_W-1:0] cfg_data,

	input  logic [ADR_W-1:0]              rd_adr,
	output logic [la_pkg::CFG_DATA_W-1:0] rd_data,

	output logic [NUM_ROUTES-1:0]         route,
	output logic                          rec_running,
	output logic [ADR_W-1:0]              rec_adr
);

	la_pkg::sample_t       sample;
	la_pkg::sample_t       cmp_value [NUM_CMP];
	la_pkg::sample_t       cmp_mask [NUM_CMP];
	logic [NUM_ROUTES-1:0] cmp_level_routes [NUM_CMP];
	logic [NUM_ROUTES-1:0] cmp_edge_routes [NUM_CMP];
	logic [NUM_ROUTES-1:0] level_out [NUM_CMP];
	logic [NUM_ROUTES-1:0] edge_out [NUM_CMP];

	logic [NUM_ROUTES-1:0] ones_set;
	logic [NUM_ROUTES-1:0] rec_start_routes;
	logic [NUM_ROUTES-1:0] rec_stop_routes;
	logic [NUM_ROUTES-1:0] rec_capture_routes;
	logic                  cmd_start;
	logic                  cmd_stop;
	logic                  cmd_capture;
	logic                  cmd_set_adr;
	logic [ADR_W-1:0]      new_adr;

	bus_sampler u_sampler (
		.pllclk    (pllclk),
		.f_reset   (f_reset),
		.adr       (adr),
		.data      (data),
		.n_rd      (n_rd),
		.n_wr      (n_wr),
		.n_cs_rom  (n_cs_rom),
		.n_cs_xram (n_cs_xram),
		.n_reset   (n_reset),
		.phi       (phi),
		.sample    (sample)
	);

	trigger_config #(
		.NUM_CMP    (NUM_CMP),
		.NUM_ROUTES (NUM_ROUTES),
		.REC_DEPTH  (REC_DEPTH)
	) u_config (
		.pllclk             (pllclk),
		.f_reset            (f_reset),
		.cfg_wr             (cfg_wr),
		.cfg_reg            (cfg_reg),
		.cfg_sel            (cfg_sel),
		.cfg_data           (cfg_data),
		.cmp_value          (cmp_value),
		.cmp_mask           (cmp_mask),
		.cmp_level_routes   (cmp_level_routes),
		.cmp_edge_routes    (cmp_edge_routes),
		.ones_set           (ones_set),
		.rec_start_routes   (rec_start_routes),
		.rec_stop_routes    (rec_stop_routes),
		.rec_capture_routes (rec_capture_routes),
		.cmd_start          (cmd_start),
		.cmd_stop           (cmd_stop),
		.cmd_capture        (cmd_capture),
		.cmd_set_adr        (cmd_set_adr),
		.new_adr            (new_adr)
	);

	// one comparator per configured slot.
	for (genvar i = 0; i < NUM_CMP; i++) begin : g_cmp
		bus_comparator #(
			.NUM_ROUTES (NUM_ROUTES)
		) u_cmp (
			.pllclk       (pllclk),
			.f_reset      (f_reset),
			.sample       (sample),
			.value        (cmp_value[i]),
			.mask         (cmp_mask[i]),
			.level_routes (cmp_level_routes[i]),
			.edge_routes  (cmp_edge_routes[i]),
			.level_out    (level_out[i]),
			.edge_out     (edge_out[i])
		);
	end

	route_combiner #(
		.NUM_CMP    (NUM_CMP),
		.NUM_ROUTES (NUM_ROUTES)
	) u_combiner (
		.pllclk   (pllclk),
		.f_reset  (f_reset),
		.ones_set (ones_set),
		.level_in (level_out),
		.edge_in  (edge_out),
		.route    (route)
	);

	recorder #(
		.NUM_ROUTES (NUM_ROUTES),
		.REC_DEPTH  (REC_DEPTH)
	) u_recorder (
		.pllclk         (pllclk),
		.f_reset        (f_reset),
		.sample         (sample),
		.route          (route),
		.start_routes   (rec_start_routes),
		.stop_routes    (rec_stop_routes),
		.capture_routes (rec_capture_routes),
		.cmd_start      (cmd_start),
		.cmd_stop       (cmd_stop),
		.cmd_capture    (cmd_capture),
		.cmd_set_adr    (cmd_set_adr),
		.new_adr        (new_adr),
		.rd_adr         (rd_adr),
		.rd_data        (rd_data),
		.rec_running    (rec_running),
		.rec_adr        (rec_adr)
	);

endmodule

// File: logic/recorder.sv
module recorder #(
	parameter int NUM_ROUTES = 6,
	parameter int REC_DEPTH  = 256,
	localparam int ADR_W     = $clog2(REC_DEPTH)
) (
	input  logic                          pllclk,
	input  logic                          f_reset,

	input  la_pkg::sample_t               sample,
	input  logic [NUM_ROUTES-1:0]         route,
	input  logic [NUM_ROUTES-1:0]         start_routes,
	input  logic [NUM_ROUTES-1:0]         stop_routes,
	input  logic [NUM_ROUTES-1:0]         capture_routes,

	input  logic                          cmd_start,
	input  logic                          cmd_stop,
	input  logic                          cmd_capture,
	input  logic                          cmd_set_adr,
	input  logic [ADR_W-1:0]              new_adr,

	input  logic [ADR_W-1:0]              rd_adr,
	output logic [la_pkg::CFG_DATA_W-1:0] rd_data,

	output logic                          rec_running,
	output logic [ADR_W-1:0]              rec_adr
);

	la_pkg::sample_t rec_mem [REC_DEPTH];
	la_pkg::sample_t sample_d1;
	la_pkg::sample_t sample_d2;

	logic start_hit;
	logic stop_hit;
	logic capture_hit;

	assign start_hit   = |(start_routes & route) || cmd_start;
	assign stop_hit    = |(stop_routes & route) || cmd_stop;
	assign capture_hit = rec_running && (|(capture_routes & route) || cmd_capture);

	// lines the sample up with the route it produced two stages later.
	always_ff @(posedge pllclk) begin
		sample_d1 <= sample;
		sample_d2 <= sample_d1;
	end

	always_ff @(posedge pllclk) begin
		if (f_reset) begin
			rec_running <= 1'b0;
			rec_adr     <= '0;
		end else begin
			if (start_hit && stop_hit)
				rec_running <= !rec_running;
			else if (start_hit)
				rec_running <= 1'b1;
			else if (stop_hit)
				rec_running <= 1'b0;

			if (cmd_set_adr)
				rec_adr <= new_adr; // wins over the capture increment.
			else if (capture_hit)
				rec_adr <= (rec_adr == ADR_W'(REC_DEPTH - 1)) ? '0 : rec_adr + 1'b1;
		end
	end

	always_ff @(posedge pllclk) begin
		if (capture_hit)
			rec_mem[rec_adr] <= sample_d2;
		rd_data <= {{(la_pkg::CFG_DATA_W - la_pkg::SAMPLE_W){1'b0}}, rec_mem[rd_adr]};
	end

endmodule

// File: logic/route_combiner.sv
module route_combiner #(
	parameter int NUM_CMP    = 2,
	parameter int NUM_ROUTES = 6
) (
	input  logic                  pllclk,
	input  logic                  f_reset,

	input  logic [NUM_ROUTES-1:0] ones_set,
	input  logic [NUM_ROUTES-1:0] level_in [NUM_CMP],
	input  logic [NUM_ROUTES-1:0] edge_in [NUM_CMP],

	output logic [NUM_ROUTES-1:0] route
);

	logic [NUM_ROUTES-1:0] route_next;

	always_comb begin
		route_next = ones_set;
		for (int i = 0; i < NUM_CMP; i++)
			route_next = route_next | level_in[i] | edge_in[i];
	end

	always_ff @(posedge pllclk) begin
		if (f_reset)
			route <= '0;
		else
			route <= route_next;
	end

endmodule

// File: logic/trigger_config.sv
module trigger_config #(
	parameter int NUM_CMP    = 2,
	parameter int NUM_ROUTES = 6,
	parameter int REC_DEPTH  = 256,
	localparam int SEL_W     = (NUM_CMP > 1) ? $clog2(NUM_CMP) : 1,
	localparam int ADR_W     = $clog2(REC_DEPTH)
) (
	input  logic                          pllclk,
	input  logic                          f_reset,

	input  logic                          cfg_wr,
	input  la_pkg::cfg_reg_e              cfg_reg,
	input  logic [SEL_W-1:0]              cfg_sel,
	input  logic [la_pkg::CFG_DATA_W-1:0] cfg_data,

	output la_pkg::sample_t               cmp_value [NUM_CMP],
	output la_pkg::sample_t               cmp_mask [NUM_CMP],
	output logic [NUM_ROUTES-1:0]         cmp_level_routes [NUM_CMP],
	output logic [NUM_ROUTES-1:0]         cmp_edge_routes [NUM_CMP],

	output logic [NUM_ROUTES-1:0]         ones_set,
	output logic [NUM_ROUTES-1:0]         rec_start_routes,
	output logic [NUM_ROUTES-1:0]         rec_stop_routes,
	output logic [NUM_ROUTES-1:0]         rec_capture_routes,

	output logic                          cmd_start,
	output logic                          cmd_stop,
	output logic                          cmd_capture,
	output logic                          cmd_set_adr,
	output logic [ADR_W-1:0]              new_adr
);

	logic ctrl_wr;

	assign ctrl_wr = cfg_wr && cfg_reg == la_pkg::CFG_REC_CONTROL;

	always_ff @(posedge pllclk) begin
		if (f_reset) begin
			ones_set           <= '0;
			rec_start_routes   <= '0;
			rec_stop_routes    <= '0;
			rec_capture_routes <= '0;
			for (int i = 0; i < NUM_CMP; i++) begin
				cmp_value[i]        <= '0;
				cmp_mask[i]         <= '0;
				cmp_level_routes[i] <= '0;
				cmp_edge_routes[i]  <= '0;
			end
		end else if (cfg_wr) begin
			case (cfg_reg)
			la_pkg::CFG_ONES_SET:
				ones_set <= cfg_data[NUM_ROUTES-1:0];
			la_pkg::CFG_CMP_VALUE:
				cmp_value[cfg_sel] <= la_pkg::sample_t'(cfg_data[la_pkg::SAMPLE_W-1:0]);
			la_pkg::CFG_CMP_MASK:
				cmp_mask[cfg_sel] <= la_pkg::sample_t'(cfg_data[la_pkg::SAMPLE_W-1:0]);
			la_pkg::CFG_CMP_LEVEL_ROUTES:
				cmp_level_routes[cfg_sel] <= cfg_data[NUM_ROUTES-1:0];
			la_pkg::CFG_CMP_EDGE_ROUTES:
				cmp_edge_routes[cfg_sel] <= cfg_data[NUM_ROUTES-1:0];
			la_pkg::CFG_REC_START_ROUTES:
				rec_start_routes <= cfg_data[NUM_ROUTES-1:0];
			la_pkg::CFG_REC_STOP_ROUTES:
				rec_stop_routes <= cfg_data[NUM_ROUTES-1:0];
			la_pkg::CFG_REC_CAPTURE_ROUTES:
				rec_capture_routes <= cfg_data[NUM_ROUTES-1:0];
			default: ; // control words only raise command pulses.
			endcase
		end
	end

	// command bits live for exactly one cycle.
	always_ff @(posedge pllclk) begin
		if (f_reset) begin
			cmd_start   <= 1'b0;
			cmd_stop    <= 1'b0;
			cmd_capture <= 1'b0;
			cmd_set_adr <= 1'b0;
		end else begin
			cmd_start   <= ctrl_wr && cfg_data[la_pkg::REC_CMD_START];
			cmd_stop    <= ctrl_wr && cfg_data[la_pkg::REC_CMD_STOP];
			cmd_capture <= ctrl_wr && cfg_data[la_pkg::REC_CMD_CAPTURE];
			cmd_set_adr <= ctrl_wr && cfg_data[la_pkg::REC_CMD_SET_ADR];
		end
	end

	always_ff @(posedge pllclk) begin
		if (f_reset)
			new_adr <= '0;
		else if (ctrl_wr)
			new_adr <= cfg_data[16 +: ADR_W]; // target of the next set command.
	end

endmodule

// File: sources.f
logic/la_pkg.sv
logic/bus_sampler.sv
logic/trigger_config.sv
logic/bus_comparator.sv
logic/route_combiner.sv
logic/recorder.sv
logic/la_top.sv
tb/la_assertions.sv
tb/la_tb.sv

// File: tb/la_assertions.sv
module la_assertions #(
	parameter int NUM_ROUTES = 6,
	parameter int ADR_W      = 8
) (
	input logic                  pllclk,
	input logic                  f_reset,
	input logic [NUM_ROUTES-1:0] route,
	input logic                  rec_running,
	input logic [ADR_W-1:0]      rec_adr,
	input logic                  cmd_set_adr
);

	timeunit 1ns;
	timeprecision 1ps;

	int fail_count = 0;

	route_cleared: assert property (@(posedge pllclk) f_reset |=> route == '0)
	else begin
		fail_count++;
		$error("route not zero after reset");
	end

	// the address only moves on a capture or a set command.
	adr_held: assert property (@(posedge pllclk) disable iff (f_reset)
		!rec_running && !cmd_set_adr |=> $stable(rec_adr))
	else begin
		fail_count++;
		$error("rec_adr moved while idle");
	end

	running_known: assert property (@(posedge pllclk) disable iff (f_reset)
		!$isunknown(rec_running))
	else begin
		fail_count++;
		$error("rec_running unknown");
	end

endmodule

bind la_top la_assertions #(
	.NUM_ROUTES (NUM_ROUTES),
	.ADR_W      (ADR_W)
) u_assert (
	.pllclk      (pllclk),
	.f_reset     (f_reset),
	.route       (route),
	.rec_running (rec_running),
	.rec_adr     (rec_adr),
	.cmd_set_adr (cmd_set_adr)
);

// File: tb/la_tb.sv
module la_tb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int NUM_CMP    = 2;
	localparam int NUM_ROUTES = 6;
	localparam int REC_DEPTH  = 256;
	localparam int SEL_W      = 1;
	localparam int ADR_W      = $clog2(REC_DEPTH);
	localparam int SETTLE     = 5; // cycles until a new setting is seen on route.
	localparam int WAIT_LIMIT = 20;

	logic                          pllclk;
	logic                          f_reset;
	logic [14:0]                   adr;
	logic [7:0]                    data;
	logic                          n_rd;
	logic                          n_wr;
	logic                          n_cs_rom;
	logic                          n_cs_xram;
	logic                          n_reset;
	logic                          phi;
	logic                          cfg_wr;
	la_pkg::cfg_reg_e              cfg_reg;
	logic [SEL_W-1:0]              cfg_sel;
	logic [la_pkg::CFG_DATA_W-1:0] cfg_data;
	logic [ADR_W-1:0]              rd_adr;
	logic [la_pkg::CFG_DATA_W-1:0] rd_data;
	logic [NUM_ROUTES-1:0]         route;
	logic                          rec_running;
	logic [ADR_W-1:0]              rec_adr;

	// settings as the testbench wrote them.
	la_pkg::sample_t       exp_value [NUM_CMP];
	la_pkg::sample_t       exp_mask [NUM_CMP];
	logic [NUM_ROUTES-1:0] exp_level [NUM_CMP];
	logic [NUM_ROUTES-1:0] exp_edge [NUM_CMP];
	logic [NUM_ROUTES-1:0] exp_ones;
	logic [NUM_CMP-1:0]    exp_prev;
	logic [NUM_ROUTES-1:0] exp_q [$];
	la_pkg::sample_t       bus_now;
	logic                  check_en;
	logic [31:0]           rng_state;

	la_top #(
		.NUM_CMP    (NUM_CMP),
		.NUM_ROUTES (NUM_ROUTES),
		.REC_DEPTH  (REC_DEPTH)
	) dut_i (
		.pllclk      (pllclk),
		.f_reset     (f_reset),
		.adr         (adr),
		.data        (data),
		.n_rd        (n_rd),
		.n_wr        (n_wr),
		.n_cs_rom    (n_cs_rom),
		.n_cs_xram   (n_cs_xram),
		.n_reset     (n_reset),
		.phi         (phi),
		.cfg_wr      (cfg_wr),
		.cfg_reg     (cfg_reg),
		.cfg_sel     (cfg_sel),
		.cfg_data    (cfg_data),
		.rd_adr      (rd_adr),
		.rd_data     (rd_data),
		.route       (route),
		.rec_running (rec_running),
		.rec_adr     (rec_adr)
	);

	always #50 pllclk = !pllclk;

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic sample_matches(input la_pkg::sample_t s, input int i);
		return (s & exp_mask[i]) == (exp_value[i] & exp_mask[i]);
	endfunction

	// expected route for one sample, given the previous match of each comparator.
	function automatic logic [NUM_ROUTES-1:0] ref_route(input la_pkg::sample_t s,
		input logic [NUM_CMP-1:0] prev);
		logic [NUM_ROUTES-1:0] r;
		r = exp_ones;
		for (int i = 0; i < NUM_CMP; i++) begin
			if (sample_matches(s, i)) begin
				r = r | exp_level[i];
				if (!prev[i])
					r = r | exp_edge[i]; // rising match only.
			end
		end
		return r;
	endfunction

	task automatic stop_on_failure(input string line);
		$display("%s", line);
		$display("Errors found");
		$fatal(1);
	endtask

	task automatic check_route(input logic [NUM_ROUTES-1:0] got,
		input logic [NUM_ROUTES-1:0] exp, input string what);
		if (got !== exp)
			stop_on_failure($sformatf("ERR %0t: %s is %h, expected %h", $time, what, got, exp));
	endtask

	task automatic check_word(input logic [la_pkg::CFG_DATA_W-1:0] got,
		input la_pkg::sample_t exp, input string what);
		if (got[la_pkg::CFG_DATA_W-1:la_pkg::SAMPLE_W] !== '0 ||
			la_pkg::sample_t'(got[la_pkg::SAMPLE_W-1:0]) !== exp)
			stop_on_failure($sformatf("ERR %0t: %s is %h, expected %h", $time, what, got, exp));
	endtask

	task automatic check_bit(input logic got, input logic exp, input string what);
		if (got !== exp)
			stop_on_failure($sformatf("ERR %0t: %s is %b, expected %b", $time, what, got, exp));
	endtask

	task automatic check_adr(input logic [ADR_W-1:0] got, input logic [ADR_W-1:0] exp,
		input string what);
		if (got !== exp)
			stop_on_failure($sformatf("ERR %0t: %s is %0d, expected %0d", $time, what, got, exp));
	endtask

	task automatic next_cycle();
		@(posedge pllclk);
		#5;
	endtask

	// pins are active low except data, adr and phi.
	task automatic drive_bus(input la_pkg::sample_t s);
		bus_now   = s;
		adr       = s.adr;
		data      = s.data;
		n_rd      = !s.rd;
		n_wr      = !s.wr;
		n_cs_rom  = !s.cs_rom;
		n_cs_xram = !s.cs_xram;
		n_reset   = !s.reset;
		phi       = s.phi;
		next_cycle();
	endtask

	task automatic next_random(output la_pkg::sample_t s);
		rng_state = xorshift(rng_state);
		s = la_pkg::sample_t'(rng_state[la_pkg::SAMPLE_W-1:0]);
	endtask

	task automatic write_cfg(input la_pkg::cfg_reg_e target, input int sel,
		input logic [31:0] wdata);
		check_en = 1'b0; // route is in transition until the write has settled.
		cfg_wr   = 1'b1;
		cfg_reg  = target;
		cfg_sel  = SEL_W'(sel);
		cfg_data = wdata;
		case (target)
		la_pkg::CFG_ONES_SET:         exp_ones = wdata[NUM_ROUTES-1:0];
		la_pkg::CFG_CMP_VALUE:        exp_value[sel] = la_pkg::sample_t'(wdata[28:0]);
		la_pkg::CFG_CMP_MASK:         exp_mask[sel] = la_pkg::sample_t'(wdata[28:0]);
		la_pkg::CFG_CMP_LEVEL_ROUTES: exp_level[sel] = wdata[NUM_ROUTES-1:0];
		la_pkg::CFG_CMP_EDGE_ROUTES:  exp_edge[sel] = wdata[NUM_ROUTES-1:0];
		default: ;
		endcase
		next_cycle();
		cfg_wr = 1'b0;
		repeat (SETTLE) next_cycle();
		check_en = 1'b1;
	endtask

	task automatic wait_stopped(input la_pkg::sample_t idle);
		int cycles;
		cycles = 0;
		while (rec_running !== 1'b0) begin
			if (cycles == WAIT_LIMIT)
				stop_on_failure("timed out waiting for rec_running to drop");
			drive_bus(idle);
			cycles++;
		end
	endtask

	// route seen now was set by the pins of three edges ago.
	always @(posedge pllclk) begin
		logic [NUM_ROUTES-1:0] expected;
		if (f_reset) begin
			exp_prev = '0;
			exp_q.delete();
		end else begin
			exp_q.push_back(ref_route(bus_now, exp_prev));
			for (int i = 0; i < NUM_CMP; i++)
				exp_prev[i] = sample_matches(bus_now, i);
			if (exp_q.size() > 3) begin
				expected = exp_q.pop_front();
				if (check_en)
					check_route(route, expected, "route");
			end
		end
	end

	always @(posedge pllclk) begin
		if (dut_i.u_assert.fail_count != 0)
			stop_on_failure("an assertion in la_assertions failed");
	end

	initial begin
		la_pkg::sample_t s;
		la_pkg::sample_t idle;
		la_pkg::sample_t rec_q [$];
		logic [31:0]     ctrl;
		logic [ADR_W-1:0] exp_adr;
		int              cnt;

		pllclk    = 1'b0;
		f_reset   = 1'b1;
		cfg_wr    = 1'b0;
		cfg_reg   = la_pkg::CFG_ONES_SET;
		cfg_sel   = '0;
		cfg_data  = '0;
		rd_adr    = '0;
		check_en  = 1'b0;
		rng_state = 32'h82fb;
		exp_ones  = '0;
		exp_prev  = '0;
		for (int i = 0; i < NUM_CMP; i++) begin
			exp_value[i] = '0;
			exp_mask[i]  = '0;
			exp_level[i] = '0;
			exp_edge[i]  = '0;
		end
		idle      = '0;
		bus_now   = idle;
		adr       = '0;
		data      = '0;
		n_rd      = 1'b1;
		n_wr      = 1'b1;
		n_cs_rom  = 1'b1;
		n_cs_xram = 1'b1;
		n_reset   = 1'b1;
		phi       = 1'b0;
		repeat (3) @(posedge pllclk);
		#5;
		f_reset = 1'b0;

		next_cycle();
		check_route(route, '0, "route after reset");
		check_bit(rec_running, 1'b0, "rec_running after reset");
		check_adr(rec_adr, '0, "rec_adr after reset");
		check_en = 1'b1;

		write_cfg(la_pkg::CFG_ONES_SET, 0, 32'h29);
		repeat (6) begin
			next_random(s);
			drive_bus(s);
			check_route(route, 6'h29, "always-one route");
		end
		write_cfg(la_pkg::CFG_ONES_SET, 0, 32'h0);

		// comparator 0 looks at the top address bits only.
		s = '0;
		s.adr = 15'h3000;
		write_cfg(la_pkg::CFG_CMP_VALUE, 0, {3'b0, s});
		s.adr = 15'h7000;
		write_cfg(la_pkg::CFG_CMP_MASK, 0, {3'b0, s});
		write_cfg(la_pkg::CFG_CMP_LEVEL_ROUTES, 0, 32'h01);
		for (int i = 0; i < 40; i++) begin
			next_random(s);
			if (i % 4 == 0)
				s.adr[14:12] = 3'b011;
			drive_bus(s);
		end

		s = '0;
		s.data = 8'ha5;
		write_cfg(la_pkg::CFG_CMP_VALUE, 1, {3'b0, s});
		s.data = 8'hff;
		write_cfg(la_pkg::CFG_CMP_MASK, 1, {3'b0, s});
		write_cfg(la_pkg::CFG_CMP_EDGE_ROUTES, 1, 32'h04);
		repeat (20) begin
			next_random(s);
			drive_bus(s);
		end
		repeat (3) drive_bus(idle);
		s = '0;
		s.data = 8'ha5;
		cnt = 0;
		repeat (8) begin
			drive_bus(s);
			if (route[2])
				cnt++;
		end
		if (cnt != 1)
			stop_on_failure($sformatf("ERR %0t: edge route high for %0d cycles, expected 1",
				$time, cnt));
		drive_bus(idle);

		// record from address 10 on the level route of comparator 0.
		write_cfg(la_pkg::CFG_REC_CAPTURE_ROUTES, 0, 32'h01);
		ctrl = '0;
		ctrl[la_pkg::REC_CMD_START]   = 1'b1;
		ctrl[la_pkg::REC_CMD_SET_ADR] = 1'b1;
		ctrl[31:16] = 16'd10;
		write_cfg(la_pkg::CFG_REC_CONTROL, 0, ctrl);
		check_bit(rec_running, 1'b1, "rec_running after start");
		check_adr(rec_adr, ADR_W'(10), "rec_adr after set");
		for (int i = 0; i < 16; i++) begin
			next_random(s);
			if (i % 3 == 0)
				s.adr[14:12] = 3'b011;
			else if (i % 5 == 1)
				s.adr[14:12] = 3'b000;
			if (sample_matches(s, 0))
				rec_q.push_back(s);
			drive_bus(s);
		end
		repeat (4) drive_bus(idle);
		exp_adr = ADR_W'(10 + rec_q.size());
		check_adr(rec_adr, exp_adr, "rec_adr after recording");
		foreach (rec_q[i]) begin
			rd_adr = ADR_W'(10 + i);
			next_cycle();
			check_word(rd_data, rec_q[i], $sformatf("recorded word %0d", i));
		end

		write_cfg(la_pkg::CFG_REC_STOP_ROUTES, 0, 32'h04);
		s = '0;
		s.data = 8'ha5;
		drive_bus(s);
		wait_stopped(idle);
		s = '0;
		s.adr = 15'h3456;
		repeat (6) drive_bus(s); // would be captured if still running.
		repeat (4) drive_bus(idle);
		check_bit(rec_running, 1'b0, "rec_running after stop");
		check_adr(rec_adr, exp_adr, "rec_adr after stop");

		if (dut_i.u_assert.fail_count == 0) begin
			$display("No errors");
			$finish;
		end else begin
			stop_on_failure("an assertion in la_assertions failed");
		end
	end

endmodule
